// ==== logic/haar_window_pkg.sv ====
`default_nettype none

package haar_window_pkg;

   // detection window in pixels.
   localparam int win_w = 8;
   localparam int win_h = 8;

   // integral image has one extra row and column of zeros.
   localparam int ii_stride = win_w + 1;
   localparam int w_addr    = $clog2(ii_stride * (win_h + 1));

   typedef logic [w_addr-1:0] corner_addr_t;

   // x, y, w, h all fit in 4 bits for an 8x8 window.
   typedef logic [3:0] coord_t;

   typedef struct packed {
      coord_t x;
      coord_t y;
      coord_t w;
      coord_t h;
   } rect_t;

endpackage

`default_nettype wire

// ==== logic/haar_cascade_pkg.sv ====
`default_nettype none

package haar_cascade_pkg;

   localparam int feature_num = 12;
   localparam int rect_num    = 3;

   localparam int w_feat = 4;
   typedef logic [w_feat-1:0] feat_idx_t;

   localparam int w_weight = 3;
   typedef logic signed [w_weight-1:0] weight_t;

   // indexed [rectangle][feature], fields are x, y, w, h.
   localparam haar_window_pkg::rect_t rect_table [rect_num][feature_num] = '{
      '{'{4'd0, 4'd0, 4'd8, 4'd8}, '{4'd0, 4'd0, 4'd8, 4'd8}, '{4'd0, 4'd0, 4'd6, 4'd8},
        '{4'd1, 4'd1, 4'd6, 4'd6}, '{4'd0, 4'd2, 4'd8, 4'd4}, '{4'd0, 4'd0, 4'd8, 4'd8},
        '{4'd2, 4'd0, 4'd4, 4'd8}, '{4'd0, 4'd1, 4'd8, 4'd6}, '{4'd0, 4'd0, 4'd4, 4'd4},
        '{4'd4, 4'd4, 4'd4, 4'd4}, '{4'd1, 4'd0, 4'd6, 4'd4}, '{4'd0, 4'd4, 4'd8, 4'd4}},
      '{'{4'd0, 4'd0, 4'd4, 4'd8}, '{4'd0, 4'd0, 4'd8, 4'd4}, '{4'd2, 4'd0, 4'd2, 4'd8},
        '{4'd2, 4'd2, 4'd4, 4'd4}, '{4'd0, 4'd3, 4'd8, 4'd2}, '{4'd0, 4'd0, 4'd4, 4'd4},
        '{4'd3, 4'd0, 4'd2, 4'd8}, '{4'd0, 4'd3, 4'd8, 4'd2}, '{4'd2, 4'd0, 4'd2, 4'd4},
        '{4'd4, 4'd4, 4'd2, 4'd2}, '{4'd3, 4'd0, 4'd2, 4'd4}, '{4'd0, 4'd6, 4'd8, 4'd2}},
      // third rectangle only used by the checker features 5 and 9.
      '{'{4'd0, 4'd0, 4'd0, 4'd0}, '{4'd0, 4'd0, 4'd0, 4'd0}, '{4'd0, 4'd0, 4'd0, 4'd0},
        '{4'd0, 4'd0, 4'd0, 4'd0}, '{4'd0, 4'd0, 4'd0, 4'd0}, '{4'd4, 4'd4, 4'd4, 4'd4},
        '{4'd0, 4'd0, 4'd0, 4'd0}, '{4'd0, 4'd0, 4'd0, 4'd0}, '{4'd0, 4'd0, 4'd0, 4'd0},
        '{4'd6, 4'd6, 4'd2, 4'd2}, '{4'd0, 4'd0, 4'd0, 4'd0}, '{4'd0, 4'd0, 4'd0, 4'd0}}
   };

   localparam weight_t weight_table [rect_num][feature_num] = '{
      '{-3'sd1, -3'sd1, -3'sd1, -3'sd1, -3'sd1, -3'sd1,
        -3'sd1, -3'sd1, -3'sd1, -3'sd1, -3'sd1, -3'sd1},
      '{3'sd2, 3'sd2, 3'sd3, 3'sd2, 3'sd2, 3'sd2,
        3'sd2, 3'sd3, 3'sd2, 3'sd2, 3'sd3, 3'sd2},
      '{3'sd0, 3'sd0, 3'sd0, 3'sd0, 3'sd0, 3'sd2,
        3'sd0, 3'sd0, 3'sd0, 3'sd2, 3'sd0, 3'sd0}
   };

   // stages end at features 2, 6 and 11.
   localparam logic [feature_num-1:0] stage_last = 12'b1000_0100_0100;

endpackage

`default_nettype wire

// ==== logic/corner_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface corner_stream_if;

   logic                          valid;
   logic                          ready;
   haar_window_pkg::corner_addr_t addr;
   logic                          eot;     // last corner of a feature.

   modport source (
      output valid,
      output addr,
      output eot,
      input  ready
   );

   modport sink (
      input  valid,
      input  addr,
      input  eot,
      output ready
   );

endinterface

`default_nettype wire

// ==== logic/rect_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module rect_addr_gen #(
   parameter int RECT_NUM = 0
) (
   input wire logic        clk,
   input wire logic        rst,
   corner_stream_if.source corner
);

   localparam haar_window_pkg::corner_addr_t stride =
      haar_window_pkg::corner_addr_t'(haar_window_pkg::ii_stride);
   localparam haar_cascade_pkg::feat_idx_t last_feat =
      haar_cascade_pkg::feat_idx_t'(haar_cascade_pkg::feature_num - 1);

   haar_cascade_pkg::feat_idx_t   feat_cnt;
   logic [1:0]                    corner_cnt;
   haar_window_pkg::rect_t        rect;
   haar_window_pkg::coord_t       col;
   haar_window_pkg::coord_t       row;
   haar_window_pkg::corner_addr_t next_addr;
   logic                          load;

   assign rect = haar_cascade_pkg::rect_table[RECT_NUM][feat_cnt];

   // corner order is tl, tr, bl, br.
   assign col = corner_cnt[0] ? rect.x + rect.w : rect.x;
   assign row = corner_cnt[1] ? rect.y + rect.h : rect.y;

   assign next_addr = haar_window_pkg::corner_addr_t'(row) * stride
                    + haar_window_pkg::corner_addr_t'(col);

   // register empty or being drained.
   assign load = !corner.valid || corner.ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         corner.valid <= 1'b0;
         corner_cnt   <= '0;
         feat_cnt     <= '0;
      end else if (load) begin
         corner.valid <= 1'b1;
         corner_cnt   <= corner_cnt + 2'd1;
         if (corner_cnt == 2'd3) begin
            if (feat_cnt == last_feat) begin
               feat_cnt <= '0;
            end else begin
               feat_cnt <= feat_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         corner.addr <= next_addr;
         corner.eot  <= (corner_cnt == 2'd3);   // bottom-right closes the feature.
      end
   end

endmodule

`default_nettype wire

// ==== logic/weight_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_rom #(
   parameter int WEIGHT_NUM = 0
) (
   input wire logic                 clk,
   input wire logic                 rst,
   output logic                     valid,
   input wire logic                 ready,
   output haar_cascade_pkg::weight_t data
);

   localparam haar_cascade_pkg::feat_idx_t last_feat =
      haar_cascade_pkg::feat_idx_t'(haar_cascade_pkg::feature_num - 1);

   haar_cascade_pkg::feat_idx_t feat_cnt;
   logic                        load;

   assign load = !valid || ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid    <= 1'b0;
         feat_cnt <= '0;
      end else if (load) begin
         valid <= 1'b1;
         if (feat_cnt == last_feat) begin
            feat_cnt <= '0;
         end else begin
            feat_cnt <= feat_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         data <= haar_cascade_pkg::weight_table[WEIGHT_NUM][feat_cnt];
      end
   end

endmodule

`default_nettype wire

// ==== logic/rects_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rects_mem (
   input wire logic                      clk,
   input wire logic                      rst,

   output logic                          addr_valid,
   input wire logic                      addr_ready,
   output haar_window_pkg::corner_addr_t addr0,
   output haar_window_pkg::corner_addr_t addr1,
   output haar_window_pkg::corner_addr_t addr2,
   output logic [1:0]                    addr_eot,

   output logic                          weight_valid,
   input wire logic                      weight_ready,
   output haar_cascade_pkg::weight_t     weight0,
   output haar_cascade_pkg::weight_t     weight1,
   output haar_cascade_pkg::weight_t     weight2
);

   localparam int n = haar_cascade_pkg::rect_num;
   localparam haar_cascade_pkg::feat_idx_t last_feat =
      haar_cascade_pkg::feat_idx_t'(haar_cascade_pkg::feature_num - 1);

   logic [n-1:0]                  rect_valid;
   logic [n-1:0]                  rect_eot;
   haar_window_pkg::corner_addr_t rect_addr [n];
   logic                          addr_xfer;
   logic                          feat_end;

   logic [n-1:0]                  wt_valid;
   haar_cascade_pkg::weight_t     wt_data [n];
   logic                          weight_xfer;

   haar_cascade_pkg::feat_idx_t   feat_idx;

   for (genvar i = 0; i < n; i++) begin : g_rect
      corner_stream_if corner_if ();

      rect_addr_gen #(
         .RECT_NUM (i)
      ) u_gen (
         .clk    (clk),
         .rst    (rst),
         .corner (corner_if.source)
      );

      assign rect_valid[i]   = corner_if.valid;
      assign rect_eot[i]     = corner_if.eot;
      assign rect_addr[i]    = corner_if.addr;
      assign corner_if.ready = addr_xfer;   // all three advance together.
   end

   for (genvar i = 0; i < n; i++) begin : g_weight
      weight_rom #(
         .WEIGHT_NUM (i)
      ) u_rom (
         .clk   (clk),
         .rst   (rst),
         .valid (wt_valid[i]),
         .ready (weight_xfer),
         .data  (wt_data[i])
      );
   end

   assign addr_valid = &rect_valid;
   assign addr_xfer  = addr_valid && addr_ready;
   assign addr0      = rect_addr[0];
   assign addr1      = rect_addr[1];
   assign addr2      = rect_addr[2];
   assign feat_end   = &rect_eot;
   assign addr_eot   = {feat_end && haar_cascade_pkg::stage_last[feat_idx], feat_end};

   assign weight_valid = &wt_valid;
   assign weight_xfer  = weight_valid && weight_ready;
   assign weight0      = wt_data[0];
   assign weight1      = wt_data[1];
   assign weight2      = wt_data[2];

   // feature of the beat currently on the address outputs.
   always_ff @(posedge clk) begin
      if (rst) begin
         feat_idx <= '0;
      end else if (addr_xfer && feat_end) begin
         if (feat_idx == last_feat) begin
            feat_idx <= '0;
         end else begin
            feat_idx <= feat_idx + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/haar_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module haar_fetch_top (
   input wire logic                          clk,
   input wire logic                          rst,

   output wire logic                         addr_valid,
   input wire logic                          addr_ready,
   output wire haar_window_pkg::corner_addr_t addr0,
   output wire haar_window_pkg::corner_addr_t addr1,
   output wire haar_window_pkg::corner_addr_t addr2,
   output wire logic [1:0]                   addr_eot,

   output wire logic                         weight_valid,
   input wire logic                          weight_ready,
   output wire haar_cascade_pkg::weight_t    weight0,
   output wire haar_cascade_pkg::weight_t    weight1,
   output wire haar_cascade_pkg::weight_t    weight2
);

   rects_mem u_rects_mem (
      .clk          (clk),
      .rst          (rst),
      .addr_valid   (addr_valid),
      .addr_ready   (addr_ready),
      .addr0        (addr0),
      .addr1        (addr1),
      .addr2        (addr2),
      .addr_eot     (addr_eot),
      .weight_valid (weight_valid),
      .weight_ready (weight_ready),
      .weight0      (weight0),
      .weight1      (weight1),
      .weight2      (weight2)
   );

endmodule

`default_nettype wire

// ==== testbench/haar_fetch_model.svh ====
`ifndef HAAR_FETCH_MODEL_SVH
`define HAAR_FETCH_MODEL_SVH

// beat n of the address stream is corner n%4 of feature (n/4)%12.
function automatic haar_window_pkg::corner_addr_t expected_corner(input int rect_idx,
                                                                  input int beat);
   haar_window_pkg::rect_t r;
   int feat;
   int row;
   int col;
   feat = (beat / 4) % haar_cascade_pkg::feature_num;
   r    = haar_cascade_pkg::rect_table[rect_idx][feat];
   col  = int'(r.x);
   row  = int'(r.y);
   if (beat % 4 == 1 || beat % 4 == 3) begin
      col = col + int'(r.w);   // right edge.
   end
   if (beat % 4 >= 2) begin
      row = row + int'(r.h);   // bottom edge.
   end
   return haar_window_pkg::corner_addr_t'(row * 9 + col);
endfunction

function automatic logic [1:0] expected_eot(input int beat);
   int   feat;
   logic last;
   feat = (beat / 4) % haar_cascade_pkg::feature_num;
   last = (beat % 4) == 3;
   return {last && (feat == 2 || feat == 6 || feat == 11), last};
endfunction

function automatic haar_cascade_pkg::weight_t expected_weight(input int rect_idx, input int beat);
   return haar_cascade_pkg::weight_table[rect_idx][beat % haar_cascade_pkg::feature_num];
endfunction

`endif

// ==== testbench/tb_haar_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_haar_fetch;

   localparam int addr_total   = 2 * haar_cascade_pkg::feature_num * 4;
   localparam int weight_total = 2 * haar_cascade_pkg::feature_num;
   localparam int timeout      = 200;

   logic                          clk;
   logic                          rst;
   logic                          addr_ready;
   logic                          weight_ready;
   logic                          addr_valid;
   haar_window_pkg::corner_addr_t addr0;
   haar_window_pkg::corner_addr_t addr1;
   haar_window_pkg::corner_addr_t addr2;
   logic [1:0]                    addr_eot;
   logic                          weight_valid;
   haar_cascade_pkg::weight_t     weight0;
   haar_cascade_pkg::weight_t     weight1;
   haar_cascade_pkg::weight_t     weight2;

   integer                        seed;
   int                            addr_beats;
   int                            weight_beats;
   int                            addr_stall;
   int                            weight_stall;

   // previous negedge sample, for the hold check.
   logic                          prev_addr_valid;
   logic                          prev_addr_ready;
   haar_window_pkg::corner_addr_t prev_addr [3];
   logic [1:0]                    prev_eot;
   logic                          prev_weight_valid;
   logic                          prev_weight_ready;
   haar_cascade_pkg::weight_t     prev_weight [3];

   `include "haar_fetch_model.svh"

   haar_fetch_top dut (
      .clk          (clk),
      .rst          (rst),
      .addr_valid   (addr_valid),
      .addr_ready   (addr_ready),
      .addr0        (addr0),
      .addr1        (addr1),
      .addr2        (addr2),
      .addr_eot     (addr_eot),
      .weight_valid (weight_valid),
      .weight_ready (weight_ready),
      .weight0      (weight0),
      .weight1      (weight1),
      .weight2      (weight2)
   );

   always #5 clk = ~clk;

   // about 70% ready on each stream.
   always @(posedge clk) begin
      addr_ready   <= ($unsigned($random(seed)) % 10) < 7;
      weight_ready <= ($unsigned($random(seed)) % 10) < 7;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_addr(input string name, input haar_window_pkg::corner_addr_t expected,
                             input haar_window_pkg::corner_addr_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("ERROR %s expected 0x%0h got 0x%0h", name, expected, actual));
      end
   endtask

   task automatic check_eot(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("ERROR %s expected 0x%0h got 0x%0h", name, expected, actual));
      end
   endtask

   task automatic check_weight(input string name, input haar_cascade_pkg::weight_t expected,
                               input haar_cascade_pkg::weight_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("ERROR %s expected 0x%0h got 0x%0h", name, expected, actual));
      end
   endtask

   // a stalled stream must keep valid and data.
   task automatic check_stable();
      if (prev_addr_valid && !prev_addr_ready) begin
         if (addr_valid !== 1'b1) begin
            abort_run("address stream dropped valid while stalled");
         end
         check_addr("addr0", prev_addr[0], addr0);
         check_addr("addr1", prev_addr[1], addr1);
         check_addr("addr2", prev_addr[2], addr2);
         check_eot("addr_eot", prev_eot, addr_eot);
      end
      if (prev_weight_valid && !prev_weight_ready) begin
         if (weight_valid !== 1'b1) begin
            abort_run("weight stream dropped valid while stalled");
         end
         check_weight("weight0", prev_weight[0], weight0);
         check_weight("weight1", prev_weight[1], weight1);
         check_weight("weight2", prev_weight[2], weight2);
      end
   endtask

   initial begin
      seed              = 30906;
      clk               = 1'b0;
      rst               = 1'b1;
      addr_ready        = 1'b0;
      weight_ready      = 1'b0;
      addr_beats        = 0;
      weight_beats      = 0;
      addr_stall        = 0;
      weight_stall      = 0;
      prev_addr_valid   = 1'b0;
      prev_addr_ready   = 1'b0;
      prev_weight_valid = 1'b0;
      prev_weight_ready = 1'b0;

      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
         if (i == 2) begin
            rst <= 1'b0;
         end
         @(negedge clk);
         if (addr_valid !== 1'b0 || weight_valid !== 1'b0) begin
            abort_run("a stream is valid during reset");
         end
      end

      while (addr_beats < addr_total || weight_beats < weight_total) begin
         @(negedge clk);
         check_stable();
         if (addr_valid && addr_eot == 2'b10) begin
            abort_run("stage end flagged without end of feature");
         end
         if (addr_beats < addr_total) begin
            if (addr_valid && addr_ready) begin
               check_addr("addr0", expected_corner(0, addr_beats), addr0);
               check_addr("addr1", expected_corner(1, addr_beats), addr1);
               check_addr("addr2", expected_corner(2, addr_beats), addr2);
               check_eot("addr_eot", expected_eot(addr_beats), addr_eot);
               addr_beats++;
               addr_stall = 0;
            end else begin
               addr_stall++;
               if (addr_stall >= timeout) begin
                  abort_run("timeout waiting for a transfer on the address stream");
               end
            end
         end
         if (weight_beats < weight_total) begin
            if (weight_valid && weight_ready) begin
               check_weight("weight0", expected_weight(0, weight_beats), weight0);
               check_weight("weight1", expected_weight(1, weight_beats), weight1);
               check_weight("weight2", expected_weight(2, weight_beats), weight2);
               weight_beats++;
               weight_stall = 0;
            end else begin
               weight_stall++;
               if (weight_stall >= timeout) begin
                  abort_run("timeout waiting for a transfer on the weight stream");
               end
            end
         end
         prev_addr_valid   = addr_valid;
         prev_addr_ready   = addr_ready;
         prev_addr[0]      = addr0;
         prev_addr[1]      = addr1;
         prev_addr[2]      = addr2;
         prev_eot          = addr_eot;
         prev_weight_valid = weight_valid;
         prev_weight_ready = weight_ready;
         prev_weight[0]    = weight0;
         prev_weight[1]    = weight1;
         prev_weight[2]    = weight2;
      end

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+testbench
logic/haar_window_pkg.sv
logic/haar_cascade_pkg.sv
logic/corner_stream_if.sv
logic/rect_addr_gen.sv
logic/weight_rom.sv
logic/rects_mem.sv
logic/haar_fetch_top.sv
testbench/tb_haar_fetch.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_haar_fetch
FILELIST  = files.f
OBJDIR    = obj_dir
PASS_MSG  = === PASS ===

.PHONY: sim clean

# the run passes only if the pass line shows up in the output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
